/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  localparam int BUS_ADDR_W = 32;
  localparam int BUS_DATA_W = 32;
  localparam int BUS_MASK_W = BUS_DATA_W / 8;

  typedef logic [BUS_ADDR_W-1:0] bus_addr_t; // Byte address
  typedef logic [BUS_DATA_W-1:0] bus_data_t;
  typedef logic [BUS_MASK_W-1:0] bus_mask_t; // One bit per byte lane

  typedef struct packed {
    logic      req;
    logic      write;
    bus_addr_t addr;
    bus_data_t data;
    bus_mask_t rd_mask;
    bus_mask_t wr_mask;
  } bus_req_t;

  typedef struct packed {
    logic      ack;
    bus_data_t data;
  } bus_rsp_t;

  // Address map
  localparam bus_addr_t MEM_ADDR_LO  = 32'h0000_0000;
  localparam bus_addr_t MEM_ADDR_HI  = 32'h0000_03FF;
  localparam bus_addr_t LED_ADDR_LO  = 32'hC000_0000;
  localparam bus_addr_t LED_ADDR_HI  = 32'hC000_FFFF;
  localparam bus_addr_t KEYS_ADDR_LO = 32'hC100_0000;
  localparam bus_addr_t KEYS_ADDR_HI = 32'hC100_FFFF;

  localparam int RAM_WORDS     = 256;
  localparam int RAM_AW        = $clog2(RAM_WORDS);
  localparam int LED_WIDTH     = 8;
  localparam int KEY_WIDTH     = 4;
  localparam int KEY_LATCH_LSB = 8; // Press latches sit in byte 1 of the key word

  typedef logic [RAM_AW-1:0] ram_idx_t;

  // Zero the byte lanes that are not selected
  function automatic bus_data_t mask_bytes(input bus_data_t data, input bus_mask_t mask);
    bus_data_t res;
    for (int i = 0; i < BUS_MASK_W; i++)
    begin
      res[8*i +: 8] = mask[i] ? data[8*i +: 8] : 8'h00;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* source/mmc.sv */
`timescale 1ns/1ns
`default_nettype none

module mmc import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  input  bus_req_t cpu_req,
  output bus_rsp_t cpu_rsp,

  output bus_req_t mem_req,
  input  bus_rsp_t mem_rsp,

  output bus_req_t led_req,
  input  bus_rsp_t led_rsp,

  output bus_req_t keys_req,
  input  bus_rsp_t keys_rsp
);

  logic mem_hit;
  logic led_hit;
  logic keys_hit;
  logic null_ack;

  // Offset compare covers lo <= addr <= hi in one unsigned test
  function automatic logic in_range(input bus_addr_t addr, input bus_addr_t lo,
                                    input bus_addr_t hi);
    return (addr - lo) <= (hi - lo);
  endfunction

  assign mem_hit  = in_range(cpu_req.addr, MEM_ADDR_LO, MEM_ADDR_HI);
  assign led_hit  = in_range(cpu_req.addr, LED_ADDR_LO, LED_ADDR_HI);
  assign keys_hit = in_range(cpu_req.addr, KEYS_ADDR_LO, KEYS_ADDR_HI);

  // CPU to targets
  always_comb
  begin
    mem_req      = cpu_req;
    mem_req.req  = cpu_req.req & mem_hit;
    mem_req.addr = cpu_req.addr - MEM_ADDR_LO;

    led_req      = cpu_req;
    led_req.req  = cpu_req.req & led_hit;
    led_req.addr = cpu_req.addr - LED_ADDR_LO;

    keys_req      = cpu_req;
    keys_req.req  = cpu_req.req & keys_hit;
    keys_req.addr = cpu_req.addr - KEYS_ADDR_LO;
  end

  // Targets to CPU, only one ack is ever high at a time
  always_comb
  begin
    cpu_rsp = '0;

    if (mem_rsp.ack)
    begin
      cpu_rsp = mem_rsp;
    end

    if (led_rsp.ack)
    begin
      cpu_rsp = led_rsp;
    end

    if (keys_rsp.ack)
    begin
      cpu_rsp = keys_rsp;
    end

    if (null_ack)
    begin
      cpu_rsp.ack  = 1'b1;
      cpu_rsp.data = '0; // Unmapped reads return zero
    end
  end

  // Null responder keeps the master from waiting forever on a hole in the map
  always_ff @(posedge clk)
  begin
    null_ack <= cpu_req.req & ~(mem_hit | led_hit | keys_hit);
    if (rst)
    begin
      null_ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/bus_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_ram import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp
);

  bus_data_t mem [RAM_WORDS];
  ram_idx_t  word_idx;
  logic      wr_en;
  logic      rd_en;

  assign word_idx = bus_req.addr[RAM_AW+1:2]; // Low two bits select a byte, ignored
  assign wr_en    = bus_req.req & bus_req.write;
  assign rd_en    = bus_req.req & ~bus_req.write;

  // Byte lane writes
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < BUS_MASK_W; i++)
      begin
        if (bus_req.wr_mask[i])
        begin
          mem[word_idx][8*i +: 8] <= bus_req.data[8*i +: 8];
        end
      end
    end
  end

  // Read data loads zero on anything but a read strobe
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      bus_rsp.data <= mask_bytes(mem[word_idx], bus_req.rd_mask);
    end
    else
    begin
      bus_rsp.data <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    bus_rsp.ack <= bus_req.req;
    if (rst)
    begin
      bus_rsp.ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/led_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module led_regs import soc_bus_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  input  bus_req_t             bus_req,
  output bus_rsp_t             bus_rsp,

  output logic [LED_WIDTH-1:0] leds
);

  logic [LED_WIDTH-1:0] led_q;
  bus_data_t            rd_word;

  assign leds    = led_q;
  assign rd_word = {{(BUS_DATA_W-LED_WIDTH){1'b0}}, led_q};

  // Same register at every offset in the range
  always_ff @(posedge clk)
  begin
    if (bus_req.req & bus_req.write & bus_req.wr_mask[0])
    begin
      led_q <= bus_req.data[LED_WIDTH-1:0];
    end
    if (rst)
    begin
      led_q <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    bus_rsp.ack  <= bus_req.req;
    bus_rsp.data <= (bus_req.req & ~bus_req.write) ? mask_bytes(rd_word, bus_req.rd_mask)
                                                   : '0;
    if (rst)
    begin
      bus_rsp.ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/keys_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module keys_regs import soc_bus_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  input  bus_req_t             bus_req,
  output bus_rsp_t             bus_rsp,

  input  logic [KEY_WIDTH-1:0] keys
);

  logic [KEY_WIDTH-1:0] sync1;
  logic [KEY_WIDTH-1:0] sync2;
  logic [KEY_WIDTH-1:0] prev;   // Last synchronized level, for edge detect
  logic [KEY_WIDTH-1:0] press;
  logic [KEY_WIDTH-1:0] latch;
  logic [KEY_WIDTH-1:0] clr;
  bus_data_t            rd_word;

  assign press = sync2 & ~prev;
  assign clr   = (bus_req.req & bus_req.write & bus_req.wr_mask[1])
               ? bus_req.data[KEY_LATCH_LSB +: KEY_WIDTH] : '0;

  always_comb
  begin
    rd_word                             = '0;
    rd_word[KEY_WIDTH-1:0]              = sync2;
    rd_word[KEY_LATCH_LSB +: KEY_WIDTH] = latch;
  end

  always_ff @(posedge clk)
  begin
    sync1 <= keys;
    sync2 <= sync1;
    prev  <= sync2;
    latch <= (latch & ~clr) | press; // A new press beats a clear in the same cycle
    if (rst)
    begin
      sync1 <= '0;
      sync2 <= '0;
      prev  <= '0;
      latch <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    bus_rsp.ack  <= bus_req.req;
    bus_rsp.data <= (bus_req.req & ~bus_req.write) ? mask_bytes(rd_word, bus_req.rd_mask)
                                                   : '0;
    if (rst)
    begin
      bus_rsp.ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/soc_bus_top.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  input  bus_req_t             cpu_req,
  output bus_rsp_t             cpu_rsp,

  output logic [LED_WIDTH-1:0] leds,
  input  logic [KEY_WIDTH-1:0] keys
);

  bus_req_t mem_req;
  bus_rsp_t mem_rsp;
  bus_req_t led_req;
  bus_rsp_t led_rsp;
  bus_req_t keys_req;
  bus_rsp_t keys_rsp;

  mmc u_mmc (
    .clk      (clk),
    .rst      (rst),
    .cpu_req  (cpu_req),
    .cpu_rsp  (cpu_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .led_req  (led_req),
    .led_rsp  (led_rsp),
    .keys_req (keys_req),
    .keys_rsp (keys_rsp)
  );

  bus_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .bus_req (mem_req),
    .bus_rsp (mem_rsp)
  );

  led_regs u_leds (
    .clk     (clk),
    .rst     (rst),
    .bus_req (led_req),
    .bus_rsp (led_rsp),
    .leds    (leds)
  );

  // Board keys are asynchronous here, keys_regs synchronizes them
  keys_regs u_keys (
    .clk     (clk),
    .rst     (rst),
    .bus_req (keys_req),
    .bus_rsp (keys_rsp),
    .keys    (keys)
  );

endmodule

`default_nettype wire

/* test/tb_soc_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_bus import soc_bus_pkg::*; ();

  // Fill, random RAM, LED, key levels, key latches, unmapped
  localparam int NUM_TXN     = 256 + 200 + 24 + 8 + 9 + 19;
  localparam int CYCLE_LIMIT = 16 + 4 * NUM_TXN + 200;

  logic                 clk;
  logic                 rst;
  bus_req_t             cpu_req;
  bus_rsp_t             cpu_rsp;
  logic [LED_WIDTH-1:0] leds;
  logic [KEY_WIDTH-1:0] keys;

  bus_data_t            ram_model [RAM_WORDS];
  logic [LED_WIDTH-1:0] led_model;
  logic [KEY_WIDTH-1:0] key_level;
  logic [KEY_WIDTH-1:0] key_latch;

  bus_data_t   exp_q [$];   // Expected read data, one entry per strobe
  bus_data_t   exp_data;
  logic        req_seen;
  int          err_count;
  int          cycle_count;
  integer      seed;
  logic [31:0] rnd;

  bus_addr_t hole_addr [8] = '{32'h0000_0400, 32'h0000_1000, 32'h8000_0000, 32'hBFFF_FFFC,
                               32'hC001_0000, 32'hC0FF_FFFC, 32'hC101_0000, 32'hC200_0000};

  soc_bus_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .leds    (leds),
    .keys    (keys)
  );

  always #50 clk = ~clk;

  function automatic bus_data_t expected_rdata(input bus_addr_t addr, input logic write,
                                               input bus_mask_t rd_mask);
    bus_data_t word;
    word = '0;
    if (write)
      return '0;
    if (addr <= MEM_ADDR_HI)
      word = ram_model[addr[RAM_AW+1:2]];
    else if (addr >= LED_ADDR_LO && addr <= LED_ADDR_HI)
      word[LED_WIDTH-1:0] = led_model;
    else if (addr >= KEYS_ADDR_LO && addr <= KEYS_ADDR_HI)
    begin
      word[KEY_WIDTH-1:0]  = key_level;
      word[8 +: KEY_WIDTH] = key_latch;
    end
    for (int i = 0; i < 4; i++)
    begin
      if (!rd_mask[i])
        word[8*i +: 8] = 8'h00;
    end
    return word;
  endfunction

  function automatic void apply_write(input bus_addr_t addr, input bus_data_t data,
                                      input bus_mask_t wr_mask);
    if (addr <= MEM_ADDR_HI)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (wr_mask[i])
          ram_model[addr[RAM_AW+1:2]][8*i +: 8] = data[8*i +: 8];
      end
    end
    else if (addr >= LED_ADDR_LO && addr <= LED_ADDR_HI && wr_mask[0])
      led_model = data[LED_WIDTH-1:0];
    else if (addr >= KEYS_ADDR_LO && addr <= KEYS_ADDR_HI && wr_mask[1])
      key_latch = key_latch & ~data[8 +: KEY_WIDTH]; // Write one to clear
  endfunction

  task automatic bus_txn(input logic write, input bus_addr_t addr, input bus_data_t data,
                         input bus_mask_t rd_mask, input bus_mask_t wr_mask);
    bus_req_t r;
    int       waited;
    r.req     = 1'b1;
    r.write   = write;
    r.addr    = addr;
    r.data    = data;
    r.rd_mask = rd_mask;
    r.wr_mask = wr_mask;
    @(posedge clk);
    cpu_req <= r;
    exp_q.push_back(expected_rdata(addr, write, rd_mask));
    if (write)
      apply_write(addr, data, wr_mask);
    @(posedge clk);
    cpu_req.req <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!cpu_rsp.ack && waited < 4)
    begin
      @(negedge clk);
      waited++;
    end
    assert (leds == led_model)
    else
    begin
      err_count++;
      $display("Mismatch leds: got %h, expected %h", leds, led_model);
    end
  endtask

  // Rising edges set latches once the synchronizers have passed them on
  task automatic set_keys(input logic [KEY_WIDTH-1:0] value);
    @(posedge clk);
    keys <= value;
    key_latch = key_latch | (value & ~key_level);
    key_level = value;
    repeat (5) @(posedge clk);
  endtask

  // Ack must follow every strobe by exactly one cycle
  always @(negedge clk)
  begin
    if (rst)
      req_seen = 1'b0;
    else
    begin
      if (req_seen)
      begin
        assert (cpu_rsp.ack)
        else
        begin
          err_count++;
          $display("No acknowledge one cycle after the request at %0t", $time);
        end
        if (exp_q.size() > 0)
        begin
          exp_data = exp_q.pop_front();
          assert (cpu_rsp.data == exp_data)
          else
          begin
            err_count++;
            $display("Mismatch cpu_rsp.data: got %h, expected %h", cpu_rsp.data, exp_data);
          end
        end
      end
      else
      begin
        assert (!cpu_rsp.ack)
        else
        begin
          err_count++;
          $display("Acknowledge without a request at %0t", $time);
        end
        assert (cpu_rsp.data == '0)
        else
        begin
          err_count++;
          $display("Mismatch cpu_rsp.data: got %h, expected %h", cpu_rsp.data, 32'h0);
        end
      end
      req_seen = cpu_req.req;
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles without finishing", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  initial
  begin
    seed      = 52199;
    clk       = 1'b0;
    rst       <= 1'b1;
    cpu_req   <= '0;
    keys      <= '0;
    err_count = 0;
    req_seen  = 1'b0;
    led_model = '0;
    key_level = '0;
    key_latch = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < RAM_WORDS; i++)
      bus_txn(1'b1, 4 * i, (32'h0101_0101 * i) ^ 32'hA5C3_0000, '0, 4'hF);

    repeat (200)
    begin
      rnd = $random(seed);
      bus_txn(rnd[10], {22'b0, rnd[9:0]}, $random(seed), rnd[15:12], rnd[19:16]);
    end

    repeat (12)
    begin
      rnd = $random(seed);
      bus_txn(1'b1, LED_ADDR_LO | {16'h0, rnd[15:0]}, $random(seed), '0, rnd[19:16]);
      bus_txn(1'b0, LED_ADDR_LO | {16'h0, rnd[31:20], 4'h0}, '0, rnd[23:20], '0);
    end

    repeat (8)
    begin
      rnd = $random(seed);
      set_keys(rnd[KEY_WIDTH-1:0]);
      bus_txn(1'b0, KEYS_ADDR_LO | {16'h0, rnd[31:16]}, '0, 4'hF, '0);
    end

    bus_txn(1'b1, KEYS_ADDR_LO, 32'h0000_0F00, '0, 4'b0010);
    set_keys('0);
    set_keys(4'b0101);
    bus_txn(1'b0, KEYS_ADDR_LO, '0, 4'b0010, '0);
    bus_txn(1'b1, KEYS_ADDR_LO, 32'h0000_0F00, '0, 4'b1101); // Lane 1 off, latches stay
    bus_txn(1'b0, KEYS_ADDR_LO + 4, '0, 4'hF, '0);
    bus_txn(1'b1, KEYS_ADDR_LO, 32'h0000_0100, '0, 4'b0010);
    bus_txn(1'b0, KEYS_ADDR_LO, '0, 4'hF, '0);
    set_keys(4'b1111);
    bus_txn(1'b0, KEYS_ADDR_LO, '0, 4'hF, '0);
    bus_txn(1'b1, KEYS_ADDR_LO, 32'h0000_0F00, '0, 4'b0010);
    bus_txn(1'b0, KEYS_ADDR_LO, '0, 4'hF, '0);

    for (int i = 0; i < 8; i++)
    begin
      bus_txn(1'b1, hole_addr[i], $random(seed), 4'hF, 4'hF);
      bus_txn(1'b0, hole_addr[i], '0, 4'hF, '0);
    end
    bus_txn(1'b0, MEM_ADDR_HI - 3, '0, 4'hF, '0); // Top RAM word, next to the hole
    bus_txn(1'b0, LED_ADDR_LO, '0, 4'hF, '0);
    bus_txn(1'b0, KEYS_ADDR_LO, '0, 4'hF, '0);

    repeat (2) @(negedge clk);
    $display("Checks done with %0d errors", err_count);
    if (err_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/soc_bus_pkg.sv
source/mmc.sv
source/bus_ram.sv
source/led_regs.sv
source/keys_regs.sv
source/soc_bus_top.sv
test/tb_soc_bus.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_soc_bus \
  -o tb_soc_bus > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "FAIL: Verilator build error"
  exit 1
fi

./obj_dir/tb_soc_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "FAIL: simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0
